// ==== source/tagctrl_pkg.sv ====
package tagctrl_pkg;

  // AXI4-Lite bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // One tag bit guards one 128-bit capability granule
  localparam int unsigned CapBytes = 16;
  localparam int unsigned NumTags  = 256;

  // Region geometry derived from the granule size and tag count
  localparam int unsigned RegionBytes = NumTags * CapBytes;
  localparam int unsigned OffsetBits  = $clog2(CapBytes);
  localparam int unsigned RegionBits  = $clog2(RegionBytes);

  typedef logic [AddrWidth-1:0]       addr_t;
  typedef logic [DataWidth-1:0]       data_t;
  typedef logic [DataWidth/8-1:0]     strb_t;
  typedef logic [1:0]                 resp_t;
  typedef logic [$clog2(NumTags)-1:0] tag_idx_t;

  // Only two response codes are ever returned
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespDecerr = 2'b11;

  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } desc_op_e;

  typedef enum logic [1:0] {
    StoreIdle  = 2'd0,
    StoreRespB = 2'd1,
    StoreRespR = 2'd2
  } store_state_e;

endpackage

// ==== source/tagctrl_desc_if.sv ====
`timescale 1ns/1ps

interface tagctrl_desc_if import tagctrl_pkg::*; ();

  // Handshake
  logic     valid;
  logic     ready;

  // Descriptor payload
  desc_op_e op;
  logic     in_range;
  tag_idx_t tag_idx;
  logic     wr_en;
  logic     wr_tag;

  modport producer (
    output valid, op, in_range, tag_idx, wr_en, wr_tag,
    input  ready
  );

  modport consumer (
    input  valid, op, in_range, tag_idx, wr_en, wr_tag,
    output ready
  );

endinterface

// ==== source/tagctrl_ax.sv ====
`timescale 1ns/1ps

module tagctrl_ax import tagctrl_pkg::*; #(
  parameter addr_t DramBase = 32'h8000_0000
) (
  input  logic             clk_i,
  input  logic             rst_i,
  // Write address channel
  input  addr_t            awaddr_i,
  input  logic             awvalid_i,
  output logic             awready_o,
  // Write data channel
  input  data_t            wdata_i,
  input  strb_t            wstrb_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  // Read address channel
  input  addr_t            araddr_i,
  input  logic             arvalid_i,
  output logic             arready_o,
  // Descriptor towards the FIFO
  tagctrl_desc_if.producer desc_o
);

  // Skid registers, one per request channel
  logic     aw_held_q, aw_held_d, aw_ready_q;
  logic     w_held_q, w_held_d, w_ready_q;
  logic     ar_held_q, ar_held_d, ar_ready_q;
  addr_t    aw_addr_q;
  addr_t    ar_addr_q;
  logic     w_en_q;
  logic     w_tag_q;

  logic     aw_acc, w_acc, ar_acc;
  logic     wr_pend, rd_pend;
  logic     slot_free;
  logic     grant_wr, grant_rd;
  logic     prio_wr_q;
  addr_t    sel_addr;
  logic     sel_in_range;

  // Output descriptor register
  logic     desc_valid_q;
  desc_op_e desc_op_q;
  logic     desc_in_range_q;
  tag_idx_t desc_idx_q;
  logic     desc_wr_en_q;
  logic     desc_wr_tag_q;

  assign aw_acc = awvalid_i & aw_ready_q;
  assign w_acc  = wvalid_i & w_ready_q;
  assign ar_acc = arvalid_i & ar_ready_q;

  // A write needs both its address and its data before it can compete
  assign wr_pend = aw_held_q & w_held_q;
  assign rd_pend = ar_held_q;

  assign slot_free = ~desc_valid_q | desc_o.ready;

  // Alternating priority between a complete write and a read
  assign grant_wr = slot_free & wr_pend & (~rd_pend | prio_wr_q);
  assign grant_rd = slot_free & rd_pend & (~wr_pend | ~prio_wr_q);

  assign aw_held_d = aw_acc | (aw_held_q & ~grant_wr);
  assign w_held_d  = w_acc | (w_held_q & ~grant_wr);
  assign ar_held_d = ar_acc | (ar_held_q & ~grant_rd);

  // Region decode relies on DramBase being aligned to the region size
  assign sel_addr     = grant_wr ? aw_addr_q : ar_addr_q;
  assign sel_in_range = (sel_addr[AddrWidth-1:RegionBits] == DramBase[AddrWidth-1:RegionBits]);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_held_q    <= 1'b0;
      w_held_q     <= 1'b0;
      ar_held_q    <= 1'b0;
      aw_ready_q   <= 1'b0;
      w_ready_q    <= 1'b0;
      ar_ready_q   <= 1'b0;
      prio_wr_q    <= 1'b1;
      desc_valid_q <= 1'b0;
    end else begin
      aw_held_q  <= aw_held_d;
      w_held_q   <= w_held_d;
      ar_held_q  <= ar_held_d;
      // Ready again as soon as the held request has been granted
      aw_ready_q <= ~aw_held_d;
      w_ready_q  <= ~w_held_d;
      ar_ready_q <= ~ar_held_d;
      if (grant_wr) begin
        prio_wr_q <= 1'b0;
      end else if (grant_rd) begin
        prio_wr_q <= 1'b1;
      end
      if (grant_wr || grant_rd) begin
        desc_valid_q <= 1'b1;
      end else if (desc_o.ready) begin
        desc_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_acc) begin
      aw_addr_q <= awaddr_i;
    end
    // Only strobe bit 0 and data bit 0 matter for a tag write
    if (w_acc) begin
      w_en_q  <= wstrb_i[0];
      w_tag_q <= wdata_i[0];
    end
    if (ar_acc) begin
      ar_addr_q <= araddr_i;
    end
    if (grant_wr || grant_rd) begin
      desc_op_q       <= grant_wr ? OpWrite : OpRead;
      desc_in_range_q <= sel_in_range;
      desc_idx_q      <= sel_addr[RegionBits-1:OffsetBits];
      desc_wr_en_q    <= grant_wr & w_en_q;
      desc_wr_tag_q   <= grant_wr & w_tag_q;
    end
  end

  assign awready_o = aw_ready_q;
  assign wready_o  = w_ready_q;
  assign arready_o = ar_ready_q;

  assign desc_o.valid    = desc_valid_q;
  assign desc_o.op       = desc_op_q;
  assign desc_o.in_range = desc_in_range_q;
  assign desc_o.tag_idx  = desc_idx_q;
  assign desc_o.wr_en    = desc_wr_en_q;
  assign desc_o.wr_tag   = desc_wr_tag_q;

endmodule

// ==== source/tagctrl_desc_fifo.sv ====
`timescale 1ns/1ps

module tagctrl_desc_fifo import tagctrl_pkg::*; #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,
  tagctrl_desc_if.consumer push_i,
  tagctrl_desc_if.producer pop_o
);

  localparam int unsigned PtrW = $clog2(FifoDepth);
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  // Payload storage, one array per descriptor field
  desc_op_e op_mem       [FifoDepth];
  logic     in_range_mem [FifoDepth];
  tag_idx_t tag_idx_mem  [FifoDepth];
  logic     wr_en_mem    [FifoDepth];
  logic     wr_tag_mem   [FifoDepth];

  ptr_t wr_ptr_q, rd_ptr_q;
  cnt_t count_q;
  logic push, pop;

  // Wrap also works for depths that are not a power of two
  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == ptr_t'(FifoDepth - 1)) begin
      return '0;
    end else begin
      return ptr + ptr_t'(1);
    end
  endfunction

  assign push_i.ready = (count_q != cnt_t'(FifoDepth));
  assign pop_o.valid  = (count_q != '0);

  assign push = push_i.valid & push_i.ready;
  assign pop  = pop_o.valid & pop_o.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + cnt_t'(1);
      end else if (pop && !push) begin
        count_q <= count_q - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_mem[wr_ptr_q]       <= push_i.op;
      in_range_mem[wr_ptr_q] <= push_i.in_range;
      tag_idx_mem[wr_ptr_q]  <= push_i.tag_idx;
      wr_en_mem[wr_ptr_q]    <= push_i.wr_en;
      wr_tag_mem[wr_ptr_q]   <= push_i.wr_tag;
    end
  end

  // Head entry is only visible once count_q has counted it
  assign pop_o.op       = op_mem[rd_ptr_q];
  assign pop_o.in_range = in_range_mem[rd_ptr_q];
  assign pop_o.tag_idx  = tag_idx_mem[rd_ptr_q];
  assign pop_o.wr_en    = wr_en_mem[rd_ptr_q];
  assign pop_o.wr_tag   = wr_tag_mem[rd_ptr_q];

endmodule

// ==== source/tagctrl_tag_store.sv ====
`timescale 1ns/1ps

module tagctrl_tag_store import tagctrl_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  tagctrl_desc_if.consumer desc_i,
  // Write response channel
  output resp_t            bresp_o,
  output logic             bvalid_o,
  input  logic             bready_i,
  // Read data channel
  output data_t            rdata_o,
  output resp_t            rresp_o,
  output logic             rvalid_o,
  input  logic             rready_i
);

  // One bit per granule of the region
  logic [NumTags-1:0] tag_q;

  store_state_e state_q, state_d;
  resp_t        bresp_q;
  resp_t        rresp_q;
  data_t        rdata_q;
  logic         pop;
  logic         pop_wr;
  logic         tag_wr;
  resp_t        pop_resp;

  // Only one response can be outstanding at a time
  assign desc_i.ready = (state_q == StoreIdle);
  assign pop          = desc_i.valid & desc_i.ready;
  assign pop_wr       = pop & (desc_i.op == OpWrite);
  assign pop_resp     = desc_i.in_range ? RespOkay : RespDecerr;

  // Out-of-range or strobe-less writes leave the array alone
  assign tag_wr = pop_wr & desc_i.in_range & desc_i.wr_en;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StoreIdle: begin
        if (pop) begin
          state_d = pop_wr ? StoreRespB : StoreRespR;
        end
      end
      StoreRespB: begin
        if (bready_i) begin
          state_d = StoreIdle;
        end
      end
      StoreRespR: begin
        if (rready_i) begin
          state_d = StoreIdle;
        end
      end
      default: state_d = StoreIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= StoreIdle;
      tag_q   <= '0;
    end else begin
      state_q <= state_d;
      if (tag_wr) begin
        tag_q[desc_i.tag_idx] <= desc_i.wr_tag;
      end
    end
  end

  // Response payload is captured at the pop and held until the handshake
  always_ff @(posedge clk_i) begin
    if (pop_wr) begin
      bresp_q <= pop_resp;
    end
    if (pop && !pop_wr) begin
      rresp_q <= pop_resp;
      rdata_q <= data_t'(desc_i.in_range & tag_q[desc_i.tag_idx]);
    end
  end

  assign bvalid_o = (state_q == StoreRespB);
  assign bresp_o  = bresp_q;
  assign rvalid_o = (state_q == StoreRespR);
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;

endmodule

// ==== source/tagctrl_top.sv ====
`timescale 1ns/1ps

module tagctrl_top import tagctrl_pkg::*; #(
  parameter addr_t       DramBase  = 32'h8000_0000,
  parameter int unsigned FifoDepth = 4
) (
  input  logic  clk_i,
  input  logic  rst_i,
  // AXI4-Lite write address
  input  addr_t awaddr_i,
  input  logic  awvalid_i,
  output logic  awready_o,
  // AXI4-Lite write data
  input  data_t wdata_i,
  input  strb_t wstrb_i,
  input  logic  wvalid_i,
  output logic  wready_o,
  // AXI4-Lite write response
  output resp_t bresp_o,
  output logic  bvalid_o,
  input  logic  bready_i,
  // AXI4-Lite read address
  input  addr_t araddr_i,
  input  logic  arvalid_i,
  output logic  arready_o,
  // AXI4-Lite read data
  output data_t rdata_o,
  output resp_t rresp_o,
  output logic  rvalid_o,
  input  logic  rready_i
);

  // Producer to FIFO, and FIFO to consumer
  tagctrl_desc_if ax_desc_if ();
  tagctrl_desc_if store_desc_if ();

  tagctrl_ax #(
    .DramBase (DramBase)
  ) tagctrl_ax_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .desc_o    (ax_desc_if)
  );

  // Lets several requests wait while the B or R channel is stalled
  tagctrl_desc_fifo #(
    .FifoDepth (FifoDepth)
  ) tagctrl_desc_fifo_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .push_i (ax_desc_if),
    .pop_o  (store_desc_if)
  );

  tagctrl_tag_store tagctrl_tag_store_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .desc_i   (store_desc_if),
    .bresp_o  (bresp_o),
    .bvalid_o (bvalid_o),
    .bready_i (bready_i),
    .rdata_o  (rdata_o),
    .rresp_o  (rresp_o),
    .rvalid_o (rvalid_o),
    .rready_i (rready_i)
  );

endmodule

// ==== testbench/tagctrl_chk.sv ====
`timescale 1ns/1ps

module tagctrl_chk import tagctrl_pkg::*; (
  input logic  clk_i,
  input logic  rst_i,
  input logic  bvalid_i,
  input logic  bready_i,
  input resp_t bresp_i,
  input logic  rvalid_i,
  input logic  rready_i,
  input resp_t rresp_i,
  input data_t rdata_i
);

  // Number of failed assertions
  int unsigned err_count = 0;

  // A stalled response keeps its valid and its payload
  b_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      $error("bvalid dropped or bresp changed before bready");
      err_count++;
    end

  r_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rresp_i) && $stable(rdata_i))
    else begin
      $error("rvalid dropped or R payload changed before rready");
      err_count++;
    end

  reset_quiet_a: assert property (@(posedge clk_i) $fell(rst_i) |-> !bvalid_i && !rvalid_i)
    else begin
      $error("Response valid high in the first cycle after reset");
      err_count++;
    end

  rresp_legal_a: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i |-> (rresp_i == RespOkay) || (rresp_i == RespDecerr))
    else begin
      $error("rresp holds an unused response code");
      err_count++;
    end

endmodule

// ==== testbench/tagctrl_tb.sv ====
`timescale 1ns/1ps

module tagctrl_tb import tagctrl_pkg::*; ();

  localparam int unsigned ClkPeriod     = 4;
  localparam int unsigned NumRandom     = 300;
  // Upper bound on directed plus random requests
  localparam int unsigned NumTrans      = 340;
  localparam int unsigned TimeoutCycles = NumTrans * 40;
  localparam logic [31:0] Seed          = 32'h8a6b_3d23;
  localparam addr_t       TbBase        = 32'h8000_0000;
  localparam addr_t       RegionSize    = 32'h0000_1000;
  localparam addr_t       GranuleSize   = 32'h0000_0010;

  typedef struct packed {
    logic  is_wr;
    resp_t resp;
    data_t data;
  } exp_t;

  logic  clk_i = 1'b0;
  logic  rst_i;
  addr_t awaddr_i;
  logic  awvalid_i;
  logic  awready_o;
  data_t wdata_i;
  strb_t wstrb_i;
  logic  wvalid_i;
  logic  wready_o;
  resp_t bresp_o;
  logic  bvalid_o;
  logic  bready_i;
  addr_t araddr_i;
  logic  arvalid_i;
  logic  arready_o;
  data_t rdata_o;
  resp_t rresp_o;
  logic  rvalid_o;
  logic  rready_i;

  exp_t        exp_q[$];
  logic        tag_model [256];
  int unsigned sent_count = 0;
  int unsigned resp_count = 0;
  logic [31:0] stim_seed  = Seed;
  logic [31:0] ready_seed = Seed + 32'd1;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  tagctrl_top tagctrl_top_i (.*);

  bind tagctrl_top tagctrl_chk tagctrl_chk_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .bvalid_i (bvalid_o),
    .bready_i (bready_i),
    .bresp_i  (bresp_o),
    .rvalid_i (rvalid_o),
    .rready_i (rready_i),
    .rresp_i  (rresp_o),
    .rdata_i  (rdata_o)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Error at %0t: %s is 0x%0h, expected 0x%0h",
                               $time, name, got, exp));
    end
  endtask

  // Computes the expected response and applies writes to the model
  function automatic exp_t ref_model(input logic is_wr, input addr_t addr,
                                     input strb_t strb, input data_t data);
    exp_t        e;
    logic        hit;
    int unsigned idx;
    hit     = (addr >= TbBase) && (addr < TbBase + RegionSize);
    idx     = (addr - TbBase) / GranuleSize;
    e.is_wr = is_wr;
    e.resp  = hit ? 2'b00 : 2'b11;
    e.data  = '0;
    if (hit && is_wr && strb[0]) begin
      tag_model[idx] = data[0];
    end
    if (hit && !is_wr) begin
      e.data = {31'b0, tag_model[idx]};
    end
    return e;
  endfunction

  // Keeps acceptance order equal to grant order
  task automatic wait_idle();
    while (!(awready_o && wready_o && arready_o)) begin
      @(negedge clk_i);
    end
  endtask

  task automatic send_aw(input addr_t addr, input int unsigned dly);
    repeat (dly) @(negedge clk_i);
    awaddr_i  = addr;
    awvalid_i = 1'b1;
    while (!awready_o) @(negedge clk_i);
    @(negedge clk_i);
    awvalid_i = 1'b0;
  endtask

  task automatic send_w(input data_t data, input strb_t strb, input int unsigned dly);
    repeat (dly) @(negedge clk_i);
    wdata_i  = data;
    wstrb_i  = strb;
    wvalid_i = 1'b1;
    while (!wready_o) @(negedge clk_i);
    @(negedge clk_i);
    wvalid_i = 1'b0;
  endtask

  task automatic do_write(input addr_t addr, input data_t data, input strb_t strb);
    int unsigned aw_dly;
    int unsigned w_dly;
    wait_idle();
    aw_dly = $unsigned($random(stim_seed)) % 4;
    w_dly  = $unsigned($random(stim_seed)) % 4;
    fork
      send_aw(addr, aw_dly);
      send_w(data, strb, w_dly);
    join
    exp_q.push_back(ref_model(1'b1, addr, strb, data));
    sent_count++;
  endtask

  task automatic do_read(input addr_t addr);
    wait_idle();
    araddr_i  = addr;
    arvalid_i = 1'b1;
    while (!arready_o) @(negedge clk_i);
    @(negedge clk_i);
    arvalid_i = 1'b0;
    exp_q.push_back(ref_model(1'b0, addr, '0, '0));
    sent_count++;
  endtask

  task automatic compare_resp(input logic is_wr, input resp_t resp, input data_t data);
    exp_t e;
    if (exp_q.size() == 0) begin
      report_failure($sformatf("Error at %0t: %s response with no request outstanding",
                               $time, is_wr ? "write" : "read"));
    end else begin
      e = exp_q.pop_front();
      if (e.is_wr != is_wr) begin
        report_failure($sformatf("Error at %0t: responses left out of acceptance order",
                                 $time));
      end else begin
        check_value(is_wr ? "bresp_o" : "rresp_o", data_t'(resp), data_t'(e.resp));
        if (!is_wr) begin
          check_value("rdata_o", data, e.data);
        end
        resp_count++;
      end
    end
  endtask

  // Each B or R transfer pops the oldest expected response
  always @(posedge clk_i) begin
    if (!rst_i && bvalid_o && bready_i) begin
      compare_resp(1'b1, bresp_o, '0);
    end
    if (!rst_i && rvalid_o && rready_i) begin
      compare_resp(1'b0, rresp_o, rdata_o);
    end
  end

  always @(negedge clk_i) begin
    if (tagctrl_top_i.tagctrl_chk_i.err_count != 0) begin
      report_failure("Error: a protocol assertion on the top-level ports failed");
    end
  end

  // Random stretches of back-pressure on B and R
  initial begin
    logic [31:0] r;
    bready_i = 1'b1;
    rready_i = 1'b1;
    wait (!rst_i);
    forever begin
      r        = $random(ready_seed);
      bready_i = (r[1:0] != 2'b00);
      rready_i = (r[3:2] != 2'b00);
      repeat (r[7:4] + 1) @(negedge clk_i);
    end
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    report_failure($sformatf("Error: timeout, %0d of %0d responses arrived in %0d cycles",
                             resp_count, sent_count, TimeoutCycles));
  end

  initial begin
    int unsigned probe_idx [9] = '{0, 1, 2, 3, 64, 127, 128, 254, 255};
    int unsigned sel;
    addr_t       addr;
    logic [31:0] r;
    foreach (tag_model[i]) tag_model[i] = 1'b0;
    rst_i     = 1'b1;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wvalid_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);

    // Fresh tags read as zero
    foreach (probe_idx[k]) do_read(TbBase + probe_idx[k] * GranuleSize + 4 * (k % 4));
    // Set a tag, read it back across the granule and check the neighbours
    do_write(TbBase + 32'h54, 32'h1, 4'h1);
    do_read(TbBase + 32'h50);
    do_read(TbBase + 32'h5c);
    do_read(TbBase + 32'h40);
    do_read(TbBase + 32'h60);
    do_write(TbBase + 32'hff8, 32'hffff_ffff, 4'hf);
    do_read(TbBase + 32'hff0);
    do_read(TbBase + 32'hfe0);
    // Strobe bit 0 clear keeps the old tag
    do_write(TbBase + 32'h50, 32'h0, 4'he);
    do_read(TbBase + 32'h58);
    do_write(TbBase + 32'h90, 32'h1, 4'h2);
    do_read(TbBase + 32'h90);
    do_write(TbBase + 32'h5c, 32'hffff_fffe, 4'h1);
    do_read(TbBase + 32'h50);
    // Accesses outside the region and the alias of granule 0
    do_write(TbBase - 32'h10, 32'h1, 4'hf);
    do_write(TbBase + RegionSize, 32'h1, 4'hf);
    do_write(32'h0, 32'h1, 4'hf);
    do_write(32'hffff_fff0, 32'h1, 4'hf);
    do_read(TbBase - 32'h10);
    do_read(TbBase + RegionSize);
    do_read(32'h0);
    do_read(TbBase);

    for (int n = 0; n < NumRandom; n++) begin
      sel = $unsigned($random(stim_seed)) % 8;
      r   = $random(stim_seed);
      if (sel == 0) begin
        addr = TbBase - 32'h40 + (r & 32'h3f);
      end else if (sel == 1) begin
        addr = TbBase + RegionSize + (r & 32'hff);
      end else begin
        // Small window for frequent hits on the same granules
        addr = TbBase + (r & (sel[0] ? 32'hfff : 32'h0ff));
      end
      if (r[31]) begin
        do_write(addr, $random(stim_seed), strb_t'($random(stim_seed)));
      end else begin
        do_read(addr);
      end
    end

    while (resp_count != sent_count) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    if (bvalid_o || rvalid_o) begin
      report_failure("Error: a response is pending with no request outstanding");
    end else if (tagctrl_top_i.tagctrl_chk_i.err_count != 0) begin
      report_failure("Error: a protocol assertion on the top-level ports failed");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// ==== tagctrl_top.f ====
source/tagctrl_pkg.sv
source/tagctrl_desc_if.sv
source/tagctrl_ax.sv
source/tagctrl_desc_fifo.sv
source/tagctrl_tag_store.sv
source/tagctrl_top.sv
testbench/tagctrl_chk.sv
testbench/tagctrl_tb.sv
